// File: src/alu_types_pkg.sv
package alu_types_pkg;

  // datapath width shared by both operands and the result
  localparam int alu_data_width = 32;

  // raw opcode width as it arrives on the instruction port
  localparam int alu_opcode_width = 4;

  // cycles from an accepted instruction to its result in the pipelined build
  // one register in the operand stage and two in the result stage
  localparam int alu_pipe_latency = 3;

  // operand and result word
  typedef logic [alu_data_width-1:0] alu_data_t;

  // opcode as seen on the ports, legal or not
  typedef logic [alu_opcode_width-1:0] alu_opcode_t;

endpackage

// File: src/alu_isa_pkg.sv
package alu_isa_pkg;

  import alu_types_pkg::*;

  // instruction set, binary ops take operand b as the left side
  typedef enum logic [alu_opcode_width-1:0] {
    op_not  = 4'h0, // ~a
    op_and  = 4'h1,
    op_or   = 4'h2,
    op_xor  = 4'h3,
    op_add  = 4'h4,
    op_sub  = 4'h5, // b - a
    op_nand = 4'h6,
    op_nor  = 4'h7,
    op_xnor = 4'h8,
    op_mul  = 4'h9, // low half of b * a
    op_shl  = 4'ha, // b << a[4:0]
    op_shr  = 4'hb, // b >> a[4:0], logical
    op_slt  = 4'hc  // b < a as signed values
  } alu_op_e;

  // anything above this opcode is illegal
  localparam alu_opcode_t alu_op_last = alu_opcode_t'(op_slt);

  // true for the opcodes served by the bitwise unit
  function automatic logic is_logic_op(alu_opcode_t opcode);
    logic hit;
    case (alu_op_e'(opcode))
      op_not, op_and, op_or, op_xor,
      op_nand, op_nor, op_xnor: hit = 1'b1;
      default:                  hit = 1'b0;
    endcase
    return hit;
  endfunction

endpackage

// File: src/alu_operand_stage.sv
`timescale 1ns/1ps

module alu_operand_stage import alu_types_pkg::*, alu_isa_pkg::*; #(
  parameter bit use_pipeline = 1'b1
) (
  input  logic        alu_clk,
  input  logic        alu_resetn,
  input  alu_data_t   op_a_i,
  input  alu_data_t   op_b_i,
  input  alu_opcode_t opcode_i,
  input  logic        instr_valid_i,
  output alu_data_t   op_a_o,
  output alu_data_t   op_b_o,
  output alu_opcode_t opcode_o,
  output logic        valid_o,
  output logic        illegal_o
);

  logic illegal_in;

  // the only legality decision in the design, only meaningful with a valid instruction
  assign illegal_in = instr_valid_i && (opcode_i > alu_op_last);

  generate
    if (use_pipeline) begin : g_reg
      // first pipeline register, control part
      always_ff @(posedge alu_clk) begin
        if (!alu_resetn) begin
          valid_o   <= 1'b0;
          illegal_o <= 1'b0;
        end else begin
          valid_o   <= instr_valid_i;
          illegal_o <= illegal_in;
        end
      end

      always_ff @(posedge alu_clk) begin
        op_a_o   <= op_a_i;
        op_b_o   <= op_b_i;
        opcode_o <= opcode_i;
      end
    end else begin : g_pass
      // zero latency build, everything flows straight to the units
      assign op_a_o    = op_a_i;
      assign op_b_o    = op_b_i;
      assign opcode_o  = opcode_i;
      assign valid_o   = instr_valid_i;
      assign illegal_o = illegal_in;
    end
  endgenerate

endmodule

// File: src/alu_logic_unit.sv
`timescale 1ns/1ps

module alu_logic_unit import alu_types_pkg::*, alu_isa_pkg::*; (
  input  alu_data_t   op_a_i,
  input  alu_data_t   op_b_i,
  input  alu_opcode_t opcode_i,
  output alu_data_t   result_o
);

  // bitwise operations, b is the left operand where order would matter
  always_comb begin
    case (alu_op_e'(opcode_i))
      op_not:  result_o = ~op_a_i; // unary, b is ignored
      op_and:  result_o = op_b_i & op_a_i;
      op_or:   result_o = op_b_i | op_a_i;
      op_xor:  result_o = op_b_i ^ op_a_i;
      op_nand: result_o = ~(op_b_i & op_a_i);
      op_nor:  result_o = ~(op_b_i | op_a_i);
      op_xnor: result_o = ~(op_b_i ^ op_a_i);
      default: result_o = '0; // arith and illegal opcodes are picked up elsewhere
    endcase
  end

endmodule

// File: src/alu_arith_unit.sv
`timescale 1ns/1ps

module alu_arith_unit import alu_types_pkg::*, alu_isa_pkg::*; (
  input  alu_data_t   op_a_i,
  input  alu_data_t   op_b_i,
  input  alu_opcode_t opcode_i,
  output alu_data_t   result_o
);

  logic [$clog2(alu_data_width)-1:0] shamt;
  logic                              b_lt_a;
  alu_data_t                         product;

  // shifts use only the low bits of a, so shifting by 32 or more wraps
  assign shamt = op_a_i[$clog2(alu_data_width)-1:0];

  assign b_lt_a = $signed(op_b_i) < $signed(op_a_i);

  // the multiplier sets the critical path of this unit
  // only the low half of the product is kept
  assign product = op_b_i * op_a_i;

  always_comb begin
    case (alu_op_e'(opcode_i))
      op_add:  result_o = op_b_i + op_a_i; // carry out is dropped
      op_sub:  result_o = op_b_i - op_a_i;
      op_mul:  result_o = product;
      op_shl:  result_o = op_b_i << shamt;
      op_shr:  result_o = op_b_i >> shamt; // logical, zeros shift in
      op_slt:  result_o = alu_data_t'(b_lt_a);
      default: result_o = '0;
    endcase
  end

endmodule

// File: src/alu_result_stage.sv
`timescale 1ns/1ps

module alu_result_stage import alu_types_pkg::*, alu_isa_pkg::*; #(
  parameter bit use_pipeline = 1'b1
) (
  input  logic        alu_clk,
  input  logic        alu_resetn,
  input  alu_data_t   logic_result_i,
  input  alu_data_t   arith_result_i,
  input  alu_opcode_t opcode_i,
  input  logic        valid_i,
  input  logic        illegal_i,
  output alu_data_t   result_o,
  output logic        result_valid_o,
  output logic        illegal_op_o
);

  alu_data_t sel_result;

  // illegal opcodes always come back as zero
  always_comb begin
    if (illegal_i) begin
      sel_result = '0;
    end else if (is_logic_op(opcode_i)) begin
      sel_result = logic_result_i;
    end else begin
      sel_result = arith_result_i;
    end
  end

  generate
    if (use_pipeline) begin : g_pipe
      alu_data_t sel_result_q;
      logic      sel_valid_q;
      logic      sel_illegal_q;

      // second and third pipeline registers
      always_ff @(posedge alu_clk) begin
        if (!alu_resetn) begin
          sel_result_q   <= '0;
          sel_valid_q    <= 1'b0;
          sel_illegal_q  <= 1'b0;
          result_o       <= '0;
          result_valid_o <= 1'b0;
          illegal_op_o   <= 1'b0;
        end else begin
          sel_result_q   <= sel_result; // select register
          sel_valid_q    <= valid_i;
          sel_illegal_q  <= illegal_i;
          result_o       <= sel_result_q; // output register
          result_valid_o <= sel_valid_q;
          illegal_op_o   <= sel_illegal_q;
        end
      end
    end else begin : g_comb
      assign result_o       = sel_result;
      assign result_valid_o = valid_i;
      assign illegal_op_o   = illegal_i; // already qualified by valid in the operand stage
    end
  endgenerate

endmodule

// File: src/alu_top.sv
`timescale 1ns/1ps

module alu_top import alu_types_pkg::*; #(
  parameter bit use_pipeline = 1'b1 // 0 gives a zero latency combinational ALU
) (
  input  logic        alu_clk,
  input  logic        alu_resetn,
  input  alu_data_t   op_a_i,
  input  alu_data_t   op_b_i,
  input  alu_opcode_t opcode_i,
  input  logic        instr_valid_i,
  output alu_data_t   result_o,
  output logic        result_valid_o,
  output logic        illegal_op_o
);

  alu_data_t   op_a;
  alu_data_t   op_b;
  alu_opcode_t opcode;
  logic        valid;
  logic        illegal;
  alu_data_t   logic_result;
  alu_data_t   arith_result;

  alu_operand_stage #(
    .use_pipeline(use_pipeline)
  ) u_operand_stage (
    .alu_clk      (alu_clk),
    .alu_resetn   (alu_resetn),
    .op_a_i       (op_a_i),
    .op_b_i       (op_b_i),
    .opcode_i     (opcode_i),
    .instr_valid_i(instr_valid_i),
    .op_a_o       (op_a),
    .op_b_o       (op_b),
    .opcode_o     (opcode),
    .valid_o      (valid),
    .illegal_o    (illegal)
  );

  // both units see every instruction, the result stage picks one
  alu_logic_unit u_logic_unit (
    .op_a_i  (op_a),
    .op_b_i  (op_b),
    .opcode_i(opcode),
    .result_o(logic_result)
  );

  alu_arith_unit u_arith_unit (
    .op_a_i  (op_a),
    .op_b_i  (op_b),
    .opcode_i(opcode),
    .result_o(arith_result)
  );

  alu_result_stage #(
    .use_pipeline(use_pipeline)
  ) u_result_stage (
    .alu_clk       (alu_clk),
    .alu_resetn    (alu_resetn),
    .logic_result_i(logic_result),
    .arith_result_i(arith_result),
    .opcode_i      (opcode),
    .valid_i       (valid),
    .illegal_i     (illegal),
    .result_o      (result_o),
    .result_valid_o(result_valid_o),
    .illegal_op_o  (illegal_op_o)
  );

endmodule

// File: tb/alu_op_asserts.sv
`timescale 1ns/1ps

module alu_op_asserts import alu_types_pkg::*, alu_isa_pkg::*; #(
  parameter bit use_pipeline = 1'b1
) (
  input logic        alu_clk,
  input logic        alu_resetn,
  input alu_data_t   op_a_i,
  input alu_data_t   op_b_i,
  input alu_opcode_t opcode_i,
  input alu_data_t   result_i,
  input logic        result_valid_i,
  input logic        illegal_op_i
);

  alu_data_t   a_dly [alu_pipe_latency];
  alu_data_t   b_dly [alu_pipe_latency];
  alu_opcode_t op_dly [alu_pipe_latency];
  alu_data_t   a_chk;
  alu_data_t   b_chk;
  alu_opcode_t op_chk;

  // instruction history, one slot per register stage of the pipelined build
  always_ff @(posedge alu_clk) begin
    a_dly[0]  <= op_a_i;
    b_dly[0]  <= op_b_i;
    op_dly[0] <= opcode_i;
    for (int i = 1; i < alu_pipe_latency; i++) begin
      a_dly[i]  <= a_dly[i-1];
      b_dly[i]  <= b_dly[i-1];
      op_dly[i] <= op_dly[i-1];
    end
  end

  // the instruction whose result is on the outputs right now
  assign a_chk  = use_pipeline ? a_dly[alu_pipe_latency-1] : op_a_i;
  assign b_chk  = use_pipeline ? b_dly[alu_pipe_latency-1] : op_b_i;
  assign op_chk = use_pipeline ? op_dly[alu_pipe_latency-1] : opcode_i;

  a_not: assert property (@(posedge alu_clk) disable iff (!alu_resetn)
    result_valid_i && op_chk == op_not |-> result_i == ~a_chk)
    else $error("NOT result is not the inverse of a");
  a_and: assert property (@(posedge alu_clk) disable iff (!alu_resetn)
    result_valid_i && op_chk == op_and |-> result_i == (b_chk & a_chk))
    else $error("AND result mismatch");
  a_or: assert property (@(posedge alu_clk) disable iff (!alu_resetn)
    result_valid_i && op_chk == op_or |-> result_i == (b_chk | a_chk))
    else $error("OR result mismatch");
  a_xor: assert property (@(posedge alu_clk) disable iff (!alu_resetn)
    result_valid_i && op_chk == op_xor |-> result_i == (b_chk ^ a_chk))
    else $error("XOR result mismatch");
  a_add: assert property (@(posedge alu_clk) disable iff (!alu_resetn)
    result_valid_i && op_chk == op_add |-> result_i == b_chk + a_chk)
    else $error("ADD result is not b plus a");
  a_sub: assert property (@(posedge alu_clk) disable iff (!alu_resetn)
    result_valid_i && op_chk == op_sub |-> result_i == b_chk - a_chk)
    else $error("SUB result is not b minus a");
  a_nand: assert property (@(posedge alu_clk) disable iff (!alu_resetn)
    result_valid_i && op_chk == op_nand |-> result_i == ~(b_chk & a_chk))
    else $error("NAND result mismatch");
  a_nor: assert property (@(posedge alu_clk) disable iff (!alu_resetn)
    result_valid_i && op_chk == op_nor |-> result_i == ~(b_chk | a_chk))
    else $error("NOR result mismatch");
  a_xnor: assert property (@(posedge alu_clk) disable iff (!alu_resetn)
    result_valid_i && op_chk == op_xnor |-> result_i == ~(b_chk ^ a_chk))
    else $error("XNOR result mismatch");
  a_mul: assert property (@(posedge alu_clk) disable iff (!alu_resetn)
    result_valid_i && op_chk == op_mul |-> result_i == b_chk * a_chk)
    else $error("MUL result is not the low half of b times a");
  a_shl: assert property (@(posedge alu_clk) disable iff (!alu_resetn)
    result_valid_i && op_chk == op_shl |-> result_i == (b_chk << a_chk[4:0]))
    else $error("SHL result mismatch");
  a_shr: assert property (@(posedge alu_clk) disable iff (!alu_resetn)
    result_valid_i && op_chk == op_shr |-> result_i == (b_chk >> a_chk[4:0]))
    else $error("SHR result mismatch");
  a_slt: assert property (@(posedge alu_clk) disable iff (!alu_resetn)
    result_valid_i && op_chk == op_slt |->
    result_i == (($signed(b_chk) < $signed(a_chk)) ? 32'd1 : 32'd0))
    else $error("SLT result mismatch");

  // opcodes above the last legal one come back as zero with the flag set
  a_illegal: assert property (@(posedge alu_clk) disable iff (!alu_resetn)
    result_valid_i && op_chk > alu_op_last |-> result_i == '0 && illegal_op_i)
    else $error("illegal opcode without zero result and illegal flag");
  a_logic_legal: assert property (@(posedge alu_clk) disable iff (!alu_resetn)
    result_valid_i && is_logic_op(op_chk) |-> !illegal_op_i)
    else $error("illegal flag set for a bitwise opcode");
  a_arith_legal: assert property (@(posedge alu_clk) disable iff (!alu_resetn)
    result_valid_i && !is_logic_op(op_chk) && op_chk <= alu_op_last |-> !illegal_op_i)
    else $error("illegal flag set for an arithmetic opcode");

  // only the pipelined build has output registers that reset clears
  a_reset_quiet: assert property (@(posedge alu_clk)
    !alu_resetn && use_pipeline |=> !result_valid_i && !illegal_op_i)
    else $error("outputs active in the cycle after reset");

endmodule

bind alu_top alu_op_asserts #(
  .use_pipeline(use_pipeline)
) u_op_asserts (
  .alu_clk       (alu_clk),
  .alu_resetn    (alu_resetn),
  .op_a_i        (op_a_i),
  .op_b_i        (op_b_i),
  .opcode_i      (opcode_i),
  .result_i      (result_o),
  .result_valid_i(result_valid_o),
  .illegal_op_i  (illegal_op_o)
);

// File: tb/alu_tb.sv
`timescale 1ns/1ps

module alu_tb import alu_types_pkg::*; #(
  parameter bit use_pipeline = 1'b1
);

  localparam int clk_period      = 40;
  localparam int tbl_len         = 24;
  localparam int rand_cnt        = 200;
  localparam int watchdog_cycles = tbl_len + rand_cnt + alu_pipe_latency + 20;

  typedef struct packed {
    alu_opcode_t op;
    alu_data_t   a;
    alu_data_t   b;
    alu_data_t   res;
  } vec_t;

  typedef struct packed {
    int        idx;
    alu_data_t res;
    logic      ill;
    int        due; // rising edge count at which the result must be visible
  } expect_t;

  logic        alu_clk = 1'b0;
  logic        alu_resetn;
  alu_data_t   op_a;
  alu_data_t   op_b;
  alu_opcode_t opcode;
  logic        instr_valid;
  alu_data_t   result;
  logic        result_valid;
  logic        illegal_op;

  vec_t        vec_tbl [tbl_len];
  expect_t     exp_q [$];
  int          edge_cnt  = 0;
  int          sent_cnt  = 0;
  int          recv_cnt  = 0;
  logic [31:0] rng_state = 32'ha5a9_40d2;

  alu_top #(
    .use_pipeline(use_pipeline)
  ) dut (
    .alu_clk       (alu_clk),
    .alu_resetn    (alu_resetn),
    .op_a_i        (op_a),
    .op_b_i        (op_b),
    .opcode_i      (opcode),
    .instr_valid_i (instr_valid),
    .result_o      (result),
    .result_valid_o(result_valid),
    .illegal_op_o  (illegal_op)
  );

  initial begin
    forever #(clk_period / 2) alu_clk = ~alu_clk;
  end

  always @(posedge alu_clk) edge_cnt <= edge_cnt + 1;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1, "alu_tb stopped");
  endtask

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("error %s expected %h actual %h", name, expected, actual));
    end
  endtask

  function automatic string vec_name(input int idx);
    string s;
    if (idx < tbl_len) begin
      s = $sformatf("table %0d", idx);
    end else begin
      s = $sformatf("random %0d", idx - tbl_len);
    end
    return s;
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // b is the left operand, a the right one or the only one
  function automatic alu_data_t model_result(input alu_opcode_t op, input alu_data_t a,
                                             input alu_data_t b);
    alu_data_t r;
    case (op)
      4'h0:    r = ~a;
      4'h1:    r = b & a;
      4'h2:    r = b | a;
      4'h3:    r = b ^ a;
      4'h4:    r = b + a;
      4'h5:    r = b - a;
      4'h6:    r = ~(b & a);
      4'h7:    r = ~(b | a);
      4'h8:    r = ~(b ^ a);
      4'h9:    r = b * a; // low half only
      4'ha:    r = b << a[4:0];
      4'hb:    r = b >> a[4:0];
      4'hc:    r = ($signed(b) < $signed(a)) ? 32'd1 : 32'd0;
      default: r = '0;
    endcase
    return r;
  endfunction

  task automatic load_table();
    vec_tbl[0]  = '{4'h0, 32'h0f0f00ff, 32'h12345678, 32'hf0f0ff00};
    vec_tbl[1]  = '{4'h1, 32'hff00ff00, 32'h12345678, 32'h12005600};
    vec_tbl[2]  = '{4'h2, 32'hff00ff00, 32'h12345678, 32'hff34ff78};
    vec_tbl[3]  = '{4'h3, 32'hff00ff00, 32'h12345678, 32'hed34a978};
    vec_tbl[4]  = '{4'h4, 32'h00000001, 32'hffffffff, 32'h00000000}; // carry out lost
    vec_tbl[5]  = '{4'h4, 32'h00000001, 32'h7fffffff, 32'h80000000}; // signed overflow
    vec_tbl[6]  = '{4'h5, 32'h00000001, 32'h00000000, 32'hffffffff}; // borrow
    vec_tbl[7]  = '{4'h5, 32'h00000030, 32'h00000010, 32'hffffffe0};
    vec_tbl[8]  = '{4'h6, 32'hff00ff00, 32'h12345678, 32'hedffa9ff};
    vec_tbl[9]  = '{4'h7, 32'hff00ff00, 32'h12345678, 32'h00cb0087};
    vec_tbl[10] = '{4'h8, 32'hff00ff00, 32'h12345678, 32'h12cb5687};
    vec_tbl[11] = '{4'h9, 32'h00010001, 32'h00010001, 32'h00020001};
    vec_tbl[12] = '{4'h9, 32'hffffffff, 32'h00000007, 32'hfffffff9};
    vec_tbl[13] = '{4'ha, 32'h0000001f, 32'h00000003, 32'h80000000}; // shift by 31
    vec_tbl[14] = '{4'ha, 32'h00000021, 32'h00000001, 32'h00000002}; // only a[4:0] counts
    vec_tbl[15] = '{4'hb, 32'h0000001f, 32'h80000000, 32'h00000001};
    vec_tbl[16] = '{4'hb, 32'h00000004, 32'hf000000f, 32'h0f000000};
    vec_tbl[17] = '{4'hc, 32'hfffffffe, 32'hffffffff, 32'h00000000};
    vec_tbl[18] = '{4'hc, 32'h00000001, 32'hffffffff, 32'h00000001};
    vec_tbl[19] = '{4'hc, 32'h80000000, 32'h7fffffff, 32'h00000000};
    vec_tbl[20] = '{4'hc, 32'hffffffff, 32'h80000000, 32'h00000001};
    vec_tbl[21] = '{4'hd, 32'h00000005, 32'h00000006, 32'h00000000};
    vec_tbl[22] = '{4'he, 32'hffffffff, 32'hffffffff, 32'h00000000};
    vec_tbl[23] = '{4'hf, 32'h12345678, 32'h87654321, 32'h00000000};
  endtask

  // outputs are read on the falling edge, before new inputs go out
  task automatic check_outputs();
    expect_t e;
    if (result_valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        abort_run("result_valid_o went high with no instruction outstanding");
      end else begin
        e = exp_q.pop_front();
        recv_cnt++;
        check(vec_name(e.idx), e.res, result);
        check($sformatf("%s illegal flag", vec_name(e.idx)), 32'(e.ill), 32'(illegal_op));
        check($sformatf("%s latency edge", vec_name(e.idx)), e.due, edge_cnt);
      end
    end else if (result_valid !== 1'b0) begin
      abort_run("result_valid_o is unknown");
    end else begin
      check("idle illegal_op_o", 32'd0, 32'(illegal_op));
      if (exp_q.size() > 0 && exp_q[0].due <= edge_cnt) begin
        abort_run($sformatf("no result arrived for %s", vec_name(exp_q[0].idx)));
      end
    end
  endtask

  task automatic next_cycle();
    @(negedge alu_clk);
    check_outputs();
  endtask

  task automatic send(input alu_opcode_t op, input alu_data_t a, input alu_data_t b,
                      input alu_data_t res);
    expect_t e;
    next_cycle();
    op_a        = a;
    op_b        = b;
    opcode      = op;
    instr_valid = 1'b1;
    e.idx = sent_cnt;
    e.res = res;
    e.ill = (op > 4'hc);
    // captured at the next rising edge, the last register stage loads two edges later
    e.due = edge_cnt + 1 + (use_pipeline ? alu_pipe_latency - 1 : 0);
    exp_q.push_back(e);
    sent_cnt++;
  endtask

  task automatic idle();
    next_cycle();
    instr_valid = 1'b0;
  endtask

  initial begin
    alu_data_t   r_a;
    alu_data_t   r_b;
    alu_opcode_t r_op;
    alu_resetn  = 1'b0;
    instr_valid = 1'b0;
    opcode      = '0;
    op_a        = '0;
    op_b        = '0;
    load_table();
    repeat (2) next_cycle(); // reset covers the first two rising edges
    alu_resetn = 1'b1;
    for (int i = 0; i < tbl_len; i++) begin
      send(vec_tbl[i].op, vec_tbl[i].a, vec_tbl[i].b, vec_tbl[i].res);
    end
    repeat (4) idle(); // a gap with no instruction must stay silent
    for (int i = 0; i < rand_cnt; i++) begin
      rng_state = xorshift32(rng_state);
      r_op      = rng_state[3:0];
      rng_state = xorshift32(rng_state);
      r_a       = rng_state;
      rng_state = xorshift32(rng_state);
      r_b       = rng_state;
      send(r_op, r_a, r_b, model_result(r_op, r_a, r_b));
    end
    while (exp_q.size() > 0) begin
      idle();
    end
    repeat (alu_pipe_latency + 1) idle();
    if (recv_cnt == tbl_len + rand_cnt) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      abort_run($sformatf("%0d results seen but %0d instructions planned", recv_cnt,
                          tbl_len + rand_cnt));
    end
  end

  initial begin
    #(watchdog_cycles * clk_period);
    abort_run($sformatf("timeout after %0d clock cycles", watchdog_cycles));
  end

endmodule

// File: flist.f
src/alu_types_pkg.sv
src/alu_isa_pkg.sv
src/alu_operand_stage.sv
src/alu_logic_unit.sv
src/alu_arith_unit.sv
src/alu_result_stage.sv
src/alu_top.sv
tb/alu_op_asserts.sv
tb/alu_tb.sv

// File: Makefile
# Verilator flow for the ALU
# PIPE=1 builds the three-stage pipeline, PIPE=0 the combinational ALU

VERILATOR ?= verilator
PIPE      ?= 1
TOP       ?= alu_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
PASS_MSG  ?= Simulation PASSED

COMMON_FLAGS = --timing --assert -Guse_pipeline=$(PIPE) --top-module $(TOP) -f $(FLIST)
SIM_FLAGS   ?= --binary -j $(JOBS)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(COMMON_FLAGS)

# the run passes only when the pass line shows up in the output
sim:
	$(VERILATOR) $(SIM_FLAGS) $(COMMON_FLAGS) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
